// File: riscv_io_pkg.sv
package riscv_io_pkg;

  // width of one uart character
  localparam int unsigned UART_DATA_BITS = 8;

  typedef logic [UART_DATA_BITS-1:0] uart_byte_t;

  // 20 bits covers slow baud rates off a fast core clock
  typedef logic [19:0] baud_cnt_t;

  // frame sequencer states
  typedef enum logic [2:0] {
    IDLE,    // line high, waiting for fifo data
    START,   // start bit, line low
    DATA,    // 8 data bits, lsb first
    PARITY,  // only when parity is enabled
    STOP     // one stop bit, line high
  } tx_state_t;

  // defaults for a real board
  localparam int unsigned DEF_FIFO_DEPTH = 256;

  // roughly 115200 baud at 800 MHz
  localparam baud_cnt_t DEF_BAUD_DIVISOR = 20'd6945;

  localparam logic DEF_PAR_EN   = 1'b1;
  localparam logic DEF_PAR_TYPE = 1'b0; // 0 even, 1 odd

  // about 5 ms of contact bounce at 100 MHz
  localparam int unsigned DEF_DEBOUNCE_CYCLES = 500000;

endpackage

// File: uart_core_if.sv
`timescale 1ns/1ps

interface uart_core_if;
  import riscv_io_pkg::*;

  uart_byte_t tx_pdata;   // byte written by the core
  logic       tx_valid;   // one-cycle write strobe
  logic       fifo_full;  // strobes are lost while high
  logic       tx_busy;    // fifo or shifter still working

  // core side
  modport core (
    output tx_pdata,
    output tx_valid,
    input  fifo_full,
    input  tx_busy
  );

  // uart side
  modport periph (
    input  tx_pdata,
    input  tx_valid,
    output fifo_full,
    output tx_busy
  );

endinterface

// File: riscv_rst_sync.sv
`timescale 1ns/1ps

module riscv_rst_sync (
  input  logic i_riscv_clk ,
  input  logic i_rst_n     ,
  output logic o_rst_n_sync
);

  logic rst_meta; // first stage

  // assert quickly, release only after two clean edges
  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      rst_meta     <= 1'b0;
      o_rst_n_sync <= 1'b0;
    end else begin
      rst_meta     <= 1'b1;
      o_rst_n_sync <= rst_meta;
    end
  end

endmodule

// File: riscv_button_debouncer.sv
`timescale 1ns/1ps

module riscv_button_debouncer #(
  parameter int unsigned DEBOUNCE_CYCLES = riscv_io_pkg::DEF_DEBOUNCE_CYCLES
) (
  input  logic i_riscv_clk,
  input  logic i_rst_n    ,
  input  logic i_noisy    ,
  output logic o_debounced
);

  localparam int unsigned      CNT_W    = $clog2(DEBOUNCE_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(DEBOUNCE_CYCLES);

  logic             noisy_meta;
  logic             noisy_sync;
  logic             level_diff; // synced input disagrees with output
  logic [CNT_W-1:0] stable_cnt;

  // button is asynchronous to the core clock
  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      noisy_meta <= 1'b0;
      noisy_sync <= 1'b0;
    end else begin
      noisy_meta <= i_noisy;
      noisy_sync <= noisy_meta;
    end
  end

  assign level_diff = noisy_sync ^ o_debounced;

  // count how long the new level has held
  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      stable_cnt  <= '0;
      o_debounced <= 1'b0;
    end else if (!level_diff) begin
      stable_cnt <= '0; // bounced back, start over
    end else if (stable_cnt == CNT_DONE) begin
      o_debounced <= noisy_sync;
      stable_cnt  <= '0;
    end else begin
      stable_cnt <= stable_cnt + 1'b1;
    end
  end

endmodule

// File: uart_tx_fifo.sv
`timescale 1ns/1ps

module uart_tx_fifo #(
  parameter int unsigned FIFO_DEPTH = riscv_io_pkg::DEF_FIFO_DEPTH
) (
  input  logic                     i_riscv_clk,
  input  logic                     i_rst_n    ,
  input  logic                     i_wr_en    ,
  input  riscv_io_pkg::uart_byte_t i_wr_data  ,
  input  logic                     i_rd_en    ,
  output riscv_io_pkg::uart_byte_t o_rd_data  ,
  output logic                     o_full     ,
  output logic                     o_empty
);
  import riscv_io_pkg::*;

  localparam int unsigned      PTR_W    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned      CNT_W    = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

  uart_byte_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count; // bytes stored
  logic             wr_ok;
  logic             rd_ok;

  assign o_full  = (count == CNT_W'(FIFO_DEPTH));
  assign o_empty = (count == '0);

  // full and empty guard the pointers
  assign wr_ok = i_wr_en & ~o_full;
  assign rd_ok = i_rd_en & ~o_empty;

  // head entry, valid whenever not empty
  assign o_rd_data = mem[rd_ptr];

  always_ff @(posedge i_riscv_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= i_wr_data;
    end
  end

  // pointers wrap by hand, depth need not be a power of two
  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // none, or push and pop together
      endcase
    end
  end

endmodule

// File: uart_tx_serializer.sv
`timescale 1ns/1ps

module uart_tx_serializer #(
  parameter riscv_io_pkg::baud_cnt_t BAUD_DIVISOR = riscv_io_pkg::DEF_BAUD_DIVISOR,
  parameter logic                    PAR_EN       = riscv_io_pkg::DEF_PAR_EN      ,
  parameter logic                    PAR_TYPE     = riscv_io_pkg::DEF_PAR_TYPE
) (
  input  logic                     i_riscv_clk,
  input  logic                     i_rst_n    ,
  input  riscv_io_pkg::uart_byte_t i_data     ,
  input  logic                     i_empty    ,
  output logic                     o_pop      ,
  output logic                     o_tx_sdata ,
  output logic                     o_active
);
  import riscv_io_pkg::*;

  localparam baud_cnt_t  BAUD_LAST = BAUD_DIVISOR - baud_cnt_t'(1);
  localparam logic [2:0] LAST_BIT  = 3'(UART_DATA_BITS - 1);

  tx_state_t  state;
  baud_cnt_t  baud_cnt;   // cycles spent in the current bit
  logic [2:0] bit_idx;
  uart_byte_t shift_q;
  logic       bit_done;
  logic       parity_bit;

  assign bit_done = (baud_cnt == BAUD_LAST);

  // rotation never changes the xor of the byte
  assign parity_bit = (^shift_q) ^ PAR_TYPE;

  assign o_pop    = (state == IDLE) & ~i_empty;
  assign o_active = (state != IDLE);

  // bit timer, held at zero while idle
  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      baud_cnt <= '0;
    end else if (state == IDLE || bit_done) begin
      baud_cnt <= '0;
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      state   <= IDLE;
      bit_idx <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (o_pop) state <= START;
        end
        START: begin
          if (bit_done) begin
            state   <= DATA;
            bit_idx <= '0;
          end
        end
        DATA: begin
          if (bit_done) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == LAST_BIT) begin
              if (PAR_EN) state <= PARITY;
              else        state <= STOP;
            end
          end
        end
        PARITY: begin
          if (bit_done) state <= STOP;
        end
        STOP: begin
          if (bit_done) state <= IDLE; // next pop may follow at once
        end
        default: state <= IDLE;
      endcase
    end
  end

  // rotate right, after eight bits the byte is back in place for parity
  always_ff @(posedge i_riscv_clk) begin
    if (o_pop) begin
      shift_q <= i_data;
    end else if (state == DATA && bit_done) begin
      shift_q <= {shift_q[0], shift_q[UART_DATA_BITS-1:1]};
    end
  end

  always_comb begin
    case (state)
      START:   o_tx_sdata = 1'b0;
      DATA:    o_tx_sdata = shift_q[0];
      PARITY:  o_tx_sdata = parity_bit;
      default: o_tx_sdata = 1'b1; // idle and stop
    endcase
  end

endmodule

// File: uart_peripheral_top.sv
`timescale 1ns/1ps

module uart_peripheral_top #(
  parameter int unsigned             FIFO_DEPTH   = riscv_io_pkg::DEF_FIFO_DEPTH  ,
  parameter riscv_io_pkg::baud_cnt_t BAUD_DIVISOR = riscv_io_pkg::DEF_BAUD_DIVISOR,
  parameter logic                    PAR_EN       = riscv_io_pkg::DEF_PAR_EN      ,
  parameter logic                    PAR_TYPE     = riscv_io_pkg::DEF_PAR_TYPE
) (
  input  logic        i_riscv_clk,
  input  logic        i_rst_n    ,
  uart_core_if.periph io_core    ,
  output logic        o_tx_sdata
);
  import riscv_io_pkg::*;

  uart_byte_t fifo_rd_data;
  logic       fifo_wr_en;
  logic       fifo_full;
  logic       fifo_empty;
  logic       ser_pop;
  logic       ser_active;

  assign fifo_wr_en = io_core.tx_valid & ~fifo_full; // strobe while full is dropped

  assign io_core.fifo_full = fifo_full;
  assign io_core.tx_busy   = ser_active | ~fifo_empty;

  uart_tx_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) uart_tx_fifo_inst (
    .i_riscv_clk(i_riscv_clk     ),
    .i_rst_n    (i_rst_n         ),
    .i_wr_en    (fifo_wr_en      ),
    .i_wr_data  (io_core.tx_pdata),
    .i_rd_en    (ser_pop         ),
    .o_rd_data  (fifo_rd_data    ),
    .o_full     (fifo_full       ),
    .o_empty    (fifo_empty      )
  );

  uart_tx_serializer #(
    .BAUD_DIVISOR(BAUD_DIVISOR),
    .PAR_EN      (PAR_EN      ),
    .PAR_TYPE    (PAR_TYPE    )
  ) uart_tx_serializer_inst (
    .i_riscv_clk(i_riscv_clk ),
    .i_rst_n    (i_rst_n     ),
    .i_data     (fifo_rd_data),
    .i_empty    (fifo_empty  ),
    .o_pop      (ser_pop     ),
    .o_tx_sdata (o_tx_sdata  ),
    .o_active   (ser_active  )
  );

endmodule

// File: riscv_io_top.sv
`timescale 1ns/1ps

module riscv_io_top #(
  parameter int unsigned             FIFO_DEPTH      = riscv_io_pkg::DEF_FIFO_DEPTH     ,
  parameter riscv_io_pkg::baud_cnt_t BAUD_DIVISOR    = riscv_io_pkg::DEF_BAUD_DIVISOR   ,
  parameter logic                    PAR_EN          = riscv_io_pkg::DEF_PAR_EN         ,
  parameter logic                    PAR_TYPE        = riscv_io_pkg::DEF_PAR_TYPE       ,
  parameter int unsigned             DEBOUNCE_CYCLES = riscv_io_pkg::DEF_DEBOUNCE_CYCLES
) (
  input  logic                     i_riscv_clk                   ,
  input  logic                     i_rst_n                       ,
  input  logic                     i_riscv_top_external_interrupt,
  input  riscv_io_pkg::uart_byte_t i_riscv_top_tx_pdata          ,
  input  logic                     i_riscv_top_tx_valid          ,
  output logic                     o_riscv_top_tx_data           ,
  output logic                     o_riscv_top_tx_busy           ,
  output logic                     o_riscv_top_fifo_full         ,
  output logic                     o_riscv_top_ext_irq
);

  logic rst_n_sync; // shared by every block below

  uart_core_if uart_core_if_inst ();

  // the core's write port comes straight from the pins
  assign uart_core_if_inst.tx_pdata = i_riscv_top_tx_pdata;
  assign uart_core_if_inst.tx_valid = i_riscv_top_tx_valid;
  assign o_riscv_top_fifo_full      = uart_core_if_inst.fifo_full;
  assign o_riscv_top_tx_busy        = uart_core_if_inst.tx_busy; // active high here

  riscv_rst_sync riscv_rst_sync_inst (
    .i_riscv_clk (i_riscv_clk),
    .i_rst_n     (i_rst_n    ),
    .o_rst_n_sync(rst_n_sync )
  );

  riscv_button_debouncer #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) riscv_button_debouncer_inst (
    .i_riscv_clk(i_riscv_clk                   ),
    .i_rst_n    (rst_n_sync                    ),
    .i_noisy    (i_riscv_top_external_interrupt),
    .o_debounced(o_riscv_top_ext_irq           )
  );

  uart_peripheral_top #(
    .FIFO_DEPTH  (FIFO_DEPTH  ),
    .BAUD_DIVISOR(BAUD_DIVISOR),
    .PAR_EN      (PAR_EN      ),
    .PAR_TYPE    (PAR_TYPE    )
  ) uart_peripheral_top_inst (
    .i_riscv_clk(i_riscv_clk        ),
    .i_rst_n    (rst_n_sync         ),
    .io_core    (uart_core_if_inst  ),
    .o_tx_sdata (o_riscv_top_tx_data)
  );

endmodule

// File: riscv_io_sva.sv
`timescale 1ns/1ps

module riscv_io_sva (
  input logic                   i_riscv_clk,
  input logic                   i_rst_n    ,
  input logic                   i_full     ,
  input logic                   i_empty    ,
  input logic                   i_pop      ,
  input logic                   i_tx_sdata ,
  input riscv_io_pkg::tx_state_t i_state
);
  import riscv_io_pkg::*;

  // never both, and one pop per cycle cannot drain a full fifo at once
  a_full_empty: assert property (
    @(posedge i_riscv_clk) disable iff (!i_rst_n)
    i_full |-> !i_empty ##1 !i_empty
  ) else $error("fifo went empty together with or right after full");

  // from idle the line stays high unless a pop starts a frame
  a_idle_line: assert property (
    @(posedge i_riscv_clk) disable iff (!i_rst_n)
    (i_state == IDLE) |=> (i_tx_sdata == !$past(i_pop))
  ) else $error("serial line wrong after an idle cycle");

  // pop only with data at the head, one byte per frame
  a_pop_nonempty: assert property (
    @(posedge i_riscv_clk) disable iff (!i_rst_n)
    i_pop |-> !i_empty ##1 !i_pop
  ) else $error("serializer popped an empty fifo or popped twice");

endmodule

bind uart_peripheral_top riscv_io_sva riscv_io_sva_inst (
  .i_riscv_clk(i_riscv_clk                   ),
  .i_rst_n    (i_rst_n                       ),
  .i_full     (fifo_full                     ),
  .i_empty    (fifo_empty                    ),
  .i_pop      (ser_pop                       ),
  .i_tx_sdata (o_tx_sdata                    ),
  .i_state    (uart_tx_serializer_inst.state )
);

// File: tb_riscv_io_top.sv
`timescale 1ns/1ps

module tb_riscv_io_top;
  import riscv_io_pkg::*;

  localparam int unsigned FIFO_DEPTH      = 4;
  localparam baud_cnt_t   BAUD_DIVISOR    = 20'd8;
  localparam logic        PAR_EN          = 1'b1;
  localparam logic        PAR_TYPE        = 1'b1; // odd
  localparam int unsigned DEBOUNCE_CYCLES = 16;

  localparam int NUM_ENTRIES  = 12;
  localparam int BURST_LEN    = 8;  // back to back, longer than the fifo
  localparam int MAX_GAP      = 40;
  localparam int BIT_CYCLES   = int'(BAUD_DIVISOR);
  localparam int FRAME_CYCLES = 11 * BIT_CYCLES;
  localparam int LINE_CYCLES  = (PAR_EN ? 11 : 10) * BIT_CYCLES; // start to end of stop
  localparam int DEB_CYCLES   = 4 * (DEBOUNCE_CYCLES + 8);
  localparam int CYCLE_LIMIT  = 20 + NUM_ENTRIES * (FRAME_CYCLES + MAX_GAP) + DEB_CYCLES + 200;

  typedef struct packed {
    uart_byte_t data;
    logic [7:0] gap; // idle cycles after the write
  } stim_t;

  logic       clk;
  logic       rst_n;
  logic       button;
  uart_byte_t tx_pdata;
  logic       tx_valid;
  logic       tx_line;
  logic       tx_busy;
  logic       fifo_full;
  logic       ext_irq;

  stim_t      stim_table [NUM_ENTRIES];
  uart_byte_t accepted_q [$]; // bytes the fifo must have taken
  int         cycle_cnt   = 0;
  int         dropped_cnt = 0;
  int         decoded_cnt = 0;
  logic       full_seen   = 1'b0;

  int         model_count = 0; // bytes the fifo should hold
  int         frame_left  = 0; // cycles until the serializer is idle again
  logic       model_full;
  logic       model_busy;

  riscv_io_top #(
    .FIFO_DEPTH     (FIFO_DEPTH     ),
    .BAUD_DIVISOR   (BAUD_DIVISOR   ),
    .PAR_EN         (PAR_EN         ),
    .PAR_TYPE       (PAR_TYPE       ),
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) riscv_io_top_inst (
    .i_riscv_clk                   (clk      ),
    .i_rst_n                       (rst_n    ),
    .i_riscv_top_external_interrupt(button   ),
    .i_riscv_top_tx_pdata          (tx_pdata ),
    .i_riscv_top_tx_valid          (tx_valid ),
    .o_riscv_top_tx_data           (tx_line  ),
    .o_riscv_top_tx_busy           (tx_busy  ),
    .o_riscv_top_fifo_full         (fifo_full),
    .o_riscv_top_ext_irq           (ext_irq  )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "run stopped on error");
  endtask

  task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL %s: got 0x%02h expected 0x%02h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL %s level: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // parity rule: xor of the data bits, inverted for odd
  function automatic logic expected_parity(input uart_byte_t b);
    return PAR_TYPE ? ~(^b) : ^b;
  endfunction

  // fifo fill level and frame timing as the write and pop rules predict
  assign model_full = (model_count == FIFO_DEPTH);
  assign model_busy = (frame_left != 0) || (model_count != 0);

  always @(posedge clk) begin : ref_model
    logic pop;
    logic wr;
    if (!rst_n) begin
      model_count = 0;
      frame_left  = 0;
    end else begin
      pop         = (frame_left == 0) && (model_count != 0);
      wr          = tx_valid && !model_full;
      model_count = model_count + int'(wr) - int'(pop);
      if (pop) frame_left = LINE_CYCLES; // next pop one edge after the stop bit
      else if (frame_left != 0) frame_left--;
    end
  end

  // one strobe, kept in the model only if the model fifo had room at the edge
  task automatic write_byte(input uart_byte_t b);
    logic taken;
    @(negedge clk);
    tx_pdata = b;
    tx_valid = 1'b1;
    taken    = ~model_full;
    if (!taken) begin
      dropped_cnt = dropped_cnt + 1;
    end
    @(posedge clk);
    if (taken) accepted_q.push_back(b);
  endtask

  task automatic expect_irq(input logic level);
    int n;
    n = 0;
    @(negedge clk);
    button = level;
    while (ext_irq !== level && n < DEBOUNCE_CYCLES + 4) begin
      @(negedge clk);
      n++;
    end
    check_bit("ext_irq", ext_irq, level);
    if (n < DEBOUNCE_CYCLES + 2) begin
      fail_run("ext_irq followed the button faster than the debounce time");
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) fail_run("timeout: the test did not finish in the expected time");
  end

  // busy and full follow the model on every cycle
  always @(negedge clk) begin
    if (rst_n) begin
      check_level("tx_busy", tx_busy, model_busy);
      check_bit("fifo_full", fifo_full, model_full);
      if (fifo_full === 1'b1) full_seen = 1'b1;
    end
  end

  // rebuilds each frame from mid-bit samples
  initial begin : frame_decoder
    uart_byte_t rx;
    uart_byte_t exp;
    logic       par;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      if (tx_line == 1'b0) begin
        wait_cycles(BIT_CYCLES / 2);
        check_level("start bit", tx_line, 1'b0);
        for (int i = 0; i < 8; i++) begin
          wait_cycles(BIT_CYCLES);
          rx[i] = tx_line; // lsb first
        end
        if (PAR_EN) begin
          wait_cycles(BIT_CYCLES);
          par = tx_line;
        end
        wait_cycles(BIT_CYCLES);
        check_bit("stop bit", tx_line, 1'b1);
        if (accepted_q.size() == 0) fail_run("a frame went out that was never written");
        exp = accepted_q.pop_front();
        check_byte("tx_data frame", rx, exp);
        if (PAR_EN) check_bit("parity bit", par, expected_parity(exp));
        decoded_cnt++;
      end
    end
  end

  initial begin : main_seq
    void'($urandom(32'hdef5));
    rst_n    = 1'b0;
    button   = 1'b0;
    tx_pdata = '0;
    tx_valid = 1'b0;

    // corner bytes first, then random ones
    stim_table[0] = '{data: 8'h00, gap: 8'd0};
    stim_table[1] = '{data: 8'hff, gap: 8'd0};
    stim_table[2] = '{data: 8'h5a, gap: 8'd0};
    stim_table[3] = '{data: 8'h81, gap: 8'd0};
    for (int i = 4; i < NUM_ENTRIES; i++) begin
      stim_table[i].data = uart_byte_t'($urandom);
      stim_table[i].gap  = (i < BURST_LEN) ? 8'd0 : 8'(10 + $urandom % 30);
    end

    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    wait_cycles(4); // sync release plus a little slack
    check_level("tx_data idle", tx_line, 1'b1);
    check_level("tx_busy", tx_busy, 1'b0);
    check_bit("fifo_full", fifo_full, 1'b0);
    check_bit("ext_irq", ext_irq, 1'b0);

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      write_byte(stim_table[i].data);
      if (stim_table[i].gap != 0) begin
        @(negedge clk);
        tx_valid = 1'b0;
        wait_cycles(int'(stim_table[i].gap) - 1);
      end
    end
    @(negedge clk);
    tx_valid = 1'b0;

    while (accepted_q.size() != 0) @(negedge clk);
    wait_cycles(BIT_CYCLES); // rest of the last stop bit
    check_level("tx_busy", tx_busy, 1'b0);
    check_level("tx_data idle", tx_line, 1'b1);
    check_bit("fifo_full seen", full_seen, 1'b1);
    if (dropped_cnt == 0) fail_run("the burst never lost a write while the fifo was full");
    if (decoded_cnt + dropped_cnt != NUM_ENTRIES) fail_run("frame count does not match the writes");

    // short glitch must not get through
    @(negedge clk);
    button = 1'b1;
    wait_cycles(DEBOUNCE_CYCLES / 2);
    button = 1'b0;
    repeat (DEBOUNCE_CYCLES + 8) begin
      @(negedge clk);
      check_bit("ext_irq", ext_irq, 1'b0);
    end

    expect_irq(1'b1); // press
    wait_cycles(4);
    expect_irq(1'b0); // release

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: compile.f
riscv_io_pkg.sv
uart_core_if.sv
riscv_rst_sync.sv
riscv_button_debouncer.sv
uart_tx_fifo.sv
uart_tx_serializer.sv
uart_peripheral_top.sv
riscv_io_top.sv
riscv_io_sva.sv
tb_riscv_io_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the riscv io testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f compile.f \
  --top-module tb_riscv_io_top \
  -o sim_tb_riscv_io_top
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb_riscv_io_top
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0
